// ==== hw/csr_params.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine CSR block constants
// data width, trap causes, mstatus field bits, timer bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_XLEN            64

// mcause values
`define CSR_CAUSE_ECALL_M   64'd11
`define CSR_CAUSE_MTI       {1'b1, 63'd7}  // interrupt bit set, code 7

// mstatus bit positions
`define CSR_MSTATUS_MIE     3
`define CSR_MSTATUS_MPIE    7
`define CSR_MSTATUS_MPP_LO  11
`define CSR_MSTATUS_FS_LO   13

`define TMR_WB_DW           32
`define TMR_WB_AW           2   // word address

`endif

// ==== hw/csr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR operation and CSR address enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package csr_pkg;

    // zero is left out so an idle op field is caught
    typedef enum logic [1:0] {
        CSR_OP_RW = 2'd1,
        CSR_OP_RS = 2'd2,
        CSR_OP_RC = 2'd3
    } csr_op_e;

    // machine CSR indices
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MIP      = 12'h344,
        CSR_MCYCLE   = 12'hB00
    } csr_addr_e;

endpackage

// ==== hw/tmr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine timer register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_params.svh"

package tmr_pkg;

    // 32-bit word offsets on the timer bus
    typedef enum logic [`TMR_WB_AW-1:0] {
        TMR_MTIME_LO    = 2'd0,
        TMR_MTIME_HI    = 2'd1,
        TMR_MTIMECMP_LO = 2'd2,
        TMR_MTIMECMP_HI = 2'd3
    } tmr_reg_e;

endpackage

// ==== hw/csr_access.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR read-modify-write unit
// forms write data and write strobe for CSRRW/CSRRS/CSRRC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_params.svh"

module csr_access import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 wr_mscrstch,
    input  logic                 csr_valid,
    input  csr_op_e              csr_op,
    input  logic [`CSR_XLEN-1:0] csr_src,
    input  logic                 stall,
    input  logic [`CSR_XLEN-1:0] csr_old,
    output logic                 csr_wr_en,
    output logic [`CSR_XLEN-1:0] csr_wdata
);

    logic src_zero;
    logic op_writes;

    assign src_zero = (csr_src == '0);

    // new value from old value and source operand
    always_comb begin
        case (csr_op)
            CSR_OP_RW: csr_wdata = csr_src;
            CSR_OP_RS: csr_wdata = csr_old | csr_src;
            CSR_OP_RC: csr_wdata = csr_old & ~csr_src;
            default:   csr_wdata = csr_src;
        endcase
    end

    // set/clear with rs1 == x0 style zero source is a pure read
    always_comb begin
        case (csr_op)
            CSR_OP_RW: op_writes = 1'b1;
            CSR_OP_RS: op_writes = !src_zero;
            CSR_OP_RC: op_writes = !src_zero;
            default:   op_writes = 1'b0;
        endcase
    end

    assign csr_wr_en = csr_valid && !stall && op_writes;

    // core must never present an undefined op with a valid access
    a_op_known: assert property (
        @(posedge clk) disable iff (wr_mscrstch)
        csr_valid |-> (csr_op inside {CSR_OP_RW, CSR_OP_RS, CSR_OP_RC})
    ) else $error("csr_access: undefined csr_op with csr_valid");

endmodule

// ==== hw/csr_regfile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine CSR storage with field write masks
// trap and mret state updates, interrupt pending logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_params.svh"

module csr_regfile import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 wr_mscrstch,
    input  logic                 csr_valid,
    input  csr_addr_e            csr_idx,
    input  logic                 csr_wr_en,
    input  logic [`CSR_XLEN-1:0] csr_wdata,
    input  logic [`CSR_XLEN-1:0] pc,
    input  logic                 trap_take,
    input  logic [`CSR_XLEN-1:0] trap_cause,
    input  logic                 mret_take,
    input  logic                 tmr_irq,
    output logic [`CSR_XLEN-1:0] csr_rdata,
    output logic                 csr_illegal,
    output logic                 irq_pending,
    output logic [`CSR_XLEN-1:0] mtvec,
    output logic [`CSR_XLEN-1:0] mepc
);

    logic [`CSR_XLEN-1:0] mcycle;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:2] mtvec_base;
    logic [`CSR_XLEN-1:2] mepc_base;
    logic                 mstatus_mie;
    logic                 mstatus_mpie;
    logic [1:0]           mstatus_mpp;
    logic [1:0]           mstatus_fs;
    logic                 mie_mtie;
    logic                 mip_mtip;
    logic [`CSR_XLEN-1:0] mstatus_val;
    logic [`CSR_XLEN-1:0] rd_val;
    logic                 idx_known;
    logic                 wr_ok;

    // assembled mstatus, SD follows dirty FS
    always_comb begin
        mstatus_val = '0;
        mstatus_val[`CSR_MSTATUS_MIE]         = mstatus_mie;
        mstatus_val[`CSR_MSTATUS_MPIE]        = mstatus_mpie;
        mstatus_val[`CSR_MSTATUS_MPP_LO +: 2] = mstatus_mpp;
        mstatus_val[`CSR_MSTATUS_FS_LO +: 2]  = mstatus_fs;
        mstatus_val[`CSR_XLEN-1]              = (mstatus_fs == 2'b11);
    end

    always_comb begin
        idx_known = 1'b1;
        case (csr_idx)
            CSR_MSTATUS:  rd_val = mstatus_val;
            CSR_MIE:      rd_val = {{(`CSR_XLEN-8){1'b0}}, mie_mtie, 7'd0};
            CSR_MTVEC:    rd_val = mtvec;
            CSR_MSCRATCH: rd_val = mscratch;
            CSR_MEPC:     rd_val = mepc;
            CSR_MCAUSE:   rd_val = mcause;
            CSR_MIP:      rd_val = {{(`CSR_XLEN-8){1'b0}}, mip_mtip, 7'd0};
            CSR_MCYCLE:   rd_val = mcycle;
            default: begin
                rd_val    = '0;
                idx_known = 1'b0;
            end
        endcase
    end

    // mip is read-only here
    assign csr_illegal = csr_valid && (!idx_known || (csr_wr_en && csr_idx == CSR_MIP));
    assign csr_rdata   = csr_illegal ? '0 : rd_val;

    assign wr_ok = csr_wr_en && !csr_illegal && !trap_take;  // trap wins over a write

    assign mtvec       = {mtvec_base, 2'b00};  // direct mode only
    assign mepc        = {mepc_base, 2'b00};
    assign irq_pending = mip_mtip && mie_mtie && mstatus_mie;

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mcycle   <= '0;
            mscratch <= '0;
            mcause   <= '0;
            mtvec_base <= '0;
            mepc_base  <= '0;
            mie_mtie <= 1'b0;
            mip_mtip <= 1'b0;
        end else begin
            if (wr_ok && csr_idx == CSR_MCYCLE) mcycle <= csr_wdata;
            else                                mcycle <= mcycle + 1'b1;

            if (wr_ok && csr_idx == CSR_MSCRATCH) mscratch <= csr_wdata;
            if (wr_ok && csr_idx == CSR_MTVEC)    mtvec_base <= csr_wdata[`CSR_XLEN-1:2];
            if (wr_ok && csr_idx == CSR_MIE)      mie_mtie <= csr_wdata[7];

            if (trap_take)                             mepc_base <= pc[`CSR_XLEN-1:2];
            else if (wr_ok && csr_idx == CSR_MEPC)     mepc_base <= csr_wdata[`CSR_XLEN-1:2];

            if (trap_take)                             mcause <= trap_cause;
            else if (wr_ok && csr_idx == CSR_MCAUSE)   mcause <= csr_wdata;

            mip_mtip <= tmr_irq;  // one cycle behind the timer
        end
    end

    // mstatus fields
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= 2'b00;
            mstatus_fs   <= 2'b00;
        end else if (trap_take) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= 2'b11;
        end else if (mret_take) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= 2'b00;
        end else if (wr_ok && csr_idx == CSR_MSTATUS) begin
            mstatus_mie  <= csr_wdata[`CSR_MSTATUS_MIE];
            mstatus_mpie <= csr_wdata[`CSR_MSTATUS_MPIE];
            mstatus_mpp  <= csr_wdata[`CSR_MSTATUS_MPP_LO +: 2];
            mstatus_fs   <= csr_wdata[`CSR_MSTATUS_FS_LO +: 2];
        end
    end

    a_trap_mret_excl: assert property (
        @(posedge clk) disable iff (wr_mscrstch)
        !(trap_take && mret_take)
    ) else $error("csr_regfile: trap and mret committed in one cycle");

endmodule

// ==== hw/trap_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trap arbitration, cause select and redirect target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_params.svh"

module trap_ctrl (
    input  logic                 clk,
    input  logic                 wr_mscrstch,
    input  logic                 ecall,
    input  logic                 mret,
    input  logic                 retire_valid,
    input  logic                 stall,
    input  logic                 irq_pending,
    input  logic [`CSR_XLEN-1:0] mtvec,
    input  logic [`CSR_XLEN-1:0] mepc,
    output logic                 trap_take,
    output logic [`CSR_XLEN-1:0] trap_cause,
    output logic                 mret_take,
    output logic                 redirect_valid,
    output logic [`CSR_XLEN-1:0] redirect_pc
);

    logic irq_take;

    // interrupt only on a retiring instruction
    assign irq_take  = irq_pending && retire_valid;
    assign trap_take = !stall && (ecall || irq_take);

    // ecall has priority over the timer
    assign trap_cause = ecall ? `CSR_CAUSE_ECALL_M : `CSR_CAUSE_MTI;

    assign mret_take = !stall && mret && !trap_take;

    assign redirect_valid = trap_take || mret_take;
    assign redirect_pc    = trap_take ? mtvec : mepc;

    a_ecall_mret_excl: assert property (
        @(posedge clk) disable iff (wr_mscrstch)
        !(ecall && mret)
    ) else $error("trap_ctrl: ecall and mret raised together");

endmodule

// ==== hw/mtimer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine timer, Wishbone classic slave
// mtime counter, mtimecmp compare, timer interrupt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_params.svh"

module mtimer import tmr_pkg::*; (
    input  logic                  clk,
    input  logic                  wr_mscrstch,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  tmr_reg_e              wb_adr,
    input  logic [`TMR_WB_DW-1:0] wb_dat_w,
    output logic [`TMR_WB_DW-1:0] wb_dat_r,
    output logic                  wb_ack,
    output logic                  tmr_irq
);

    logic [2*`TMR_WB_DW-1:0] mtime;
    logic [2*`TMR_WB_DW-1:0] mtimecmp;
    logic [`TMR_WB_DW-1:0]   rd_word;
    logic                    ack_q;
    logic                    req;
    logic                    wr;

    // new request, not the cycle already acked
    assign req = wb_cyc && wb_stb && !ack_q;
    assign wr  = req && wb_we;

    always_ff @(posedge clk) begin
        if (wr_mscrstch) ack_q <= 1'b0;
        else             ack_q <= req;  // single-cycle pulse
    end

    assign wb_ack = ack_q;

    always_comb begin
        case (wb_adr)
            TMR_MTIME_LO:    rd_word = mtime[`TMR_WB_DW-1:0];
            TMR_MTIME_HI:    rd_word = mtime[2*`TMR_WB_DW-1:`TMR_WB_DW];
            TMR_MTIMECMP_LO: rd_word = mtimecmp[`TMR_WB_DW-1:0];
            TMR_MTIMECMP_HI: rd_word = mtimecmp[2*`TMR_WB_DW-1:`TMR_WB_DW];
            default:         rd_word = '0;
        endcase
    end

    // read data captured with the ack
    always_ff @(posedge clk) begin
        if (req) wb_dat_r <= rd_word;
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtime    <= '0;
            mtimecmp <= '1;  // no interrupt until programmed
        end else begin
            if (wr && wb_adr == TMR_MTIME_LO)
                mtime <= {mtime[2*`TMR_WB_DW-1:`TMR_WB_DW], wb_dat_w};
            else if (wr && wb_adr == TMR_MTIME_HI)
                mtime <= {wb_dat_w, mtime[`TMR_WB_DW-1:0]};
            else
                mtime <= mtime + 1'b1;

            if (wr && wb_adr == TMR_MTIMECMP_LO)
                mtimecmp[`TMR_WB_DW-1:0] <= wb_dat_w;
            if (wr && wb_adr == TMR_MTIMECMP_HI)
                mtimecmp[2*`TMR_WB_DW-1:`TMR_WB_DW] <= wb_dat_w;
        end
    end

    assign tmr_irq = (mtime >= mtimecmp);

    // classic master keeps its request up through the ack cycle
    a_ack_held_req: assert property (
        @(posedge clk) disable iff (wr_mscrstch)
        wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("mtimer: wb_ack after the master dropped its strobe");

endmodule

// ==== hw/mcsr_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine-mode CSR block top level
// CSR access unit, CSR file, trap control, machine timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_params.svh"

module mcsr_top import csr_pkg::*, tmr_pkg::*; (
    input  logic                  clk,
    input  logic                  wr_mscrstch,
    // core side
    input  logic                  csr_valid,
    input  csr_op_e               csr_op,
    input  csr_addr_e             csr_idx,
    input  logic [`CSR_XLEN-1:0]  csr_src,
    input  logic                  stall,
    input  logic                  retire_valid,
    input  logic [`CSR_XLEN-1:0]  pc,
    input  logic                  ecall,
    input  logic                  mret,
    output logic [`CSR_XLEN-1:0]  csr_rdata,
    output logic                  csr_illegal,
    output logic                  redirect_valid,
    output logic [`CSR_XLEN-1:0]  redirect_pc,
    // timer bus
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  tmr_reg_e              wb_adr,
    input  logic [`TMR_WB_DW-1:0] wb_dat_w,
    output logic [`TMR_WB_DW-1:0] wb_dat_r,
    output logic                  wb_ack
);

    logic                 csr_wr_en;
    logic [`CSR_XLEN-1:0] csr_wdata;
    logic                 irq_pending;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;
    logic                 tmr_irq;
    logic                 trap_take;
    logic [`CSR_XLEN-1:0] trap_cause;
    logic                 mret_take;

    csr_access u_csr_access (
        .clk(clk), .wr_mscrstch(wr_mscrstch), .csr_valid(csr_valid), .csr_op(csr_op),
        .csr_src(csr_src), .stall(stall), .csr_old(csr_rdata),  // old value from the file
        .csr_wr_en(csr_wr_en), .csr_wdata(csr_wdata)
    );

    csr_regfile u_csr_regfile (
        .clk(clk), .wr_mscrstch(wr_mscrstch), .csr_valid(csr_valid), .csr_idx(csr_idx),
        .csr_wr_en(csr_wr_en), .csr_wdata(csr_wdata), .pc(pc), .trap_take(trap_take),
        .trap_cause(trap_cause), .mret_take(mret_take), .tmr_irq(tmr_irq),
        .csr_rdata(csr_rdata), .csr_illegal(csr_illegal), .irq_pending(irq_pending),
        .mtvec(mtvec), .mepc(mepc)
    );

    trap_ctrl u_trap_ctrl (
        .clk(clk), .wr_mscrstch(wr_mscrstch), .ecall(ecall), .mret(mret),
        .retire_valid(retire_valid), .stall(stall), .irq_pending(irq_pending),
        .mtvec(mtvec), .mepc(mepc), .trap_take(trap_take), .trap_cause(trap_cause),
        .mret_take(mret_take), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    mtimer u_mtimer (
        .clk(clk), .wr_mscrstch(wr_mscrstch), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack), .tmr_irq(tmr_irq)
    );

endmodule

// ==== verif/tb_mcsr.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the machine CSR block
// clock, reset, watchdog, CSR and timer bus tasks, checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "csr_params.svh"

module tb_mcsr import csr_pkg::*, tmr_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned ACK_LIMIT  = 4;
    localparam int unsigned TMR_MARGIN = 40;   // timer compare lead, in cycles
    localparam int unsigned CYC_TOTAL  = 6 + 40 + 40 + 10 + 20
                                       + 6 * (ACK_LIMIT + 3)
                                       + 4 * (ACK_LIMIT + 3) + 2 * TMR_MARGIN + 40;
    localparam int unsigned WATCHDOG_NS = 2 * 10 * CYC_TOTAL;

    logic                  clk;
    logic                  wr_mscrstch;
    logic                  csr_valid;
    csr_op_e               csr_op;
    csr_addr_e             csr_idx;
    logic [`CSR_XLEN-1:0]  csr_src;
    logic                  stall;
    logic                  retire_valid;
    logic [`CSR_XLEN-1:0]  pc;
    logic                  ecall;
    logic                  mret;
    logic [`CSR_XLEN-1:0]  csr_rdata;
    logic                  csr_illegal;
    logic                  redirect_valid;
    logic [`CSR_XLEN-1:0]  redirect_pc;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    tmr_reg_e              wb_adr;
    logic [`TMR_WB_DW-1:0] wb_dat_w;
    logic [`TMR_WB_DW-1:0] wb_dat_r;
    logic                  wb_ack;

    logic [31:0] lfsr_state = 32'hbd12f471;
    logic [63:0] scratch_model;

    mcsr_top UUT (.*);

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got 0x%h, expected 0x%h",
                                $time, name, got, exp));
    endtask

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [63:0] rand_bits(input int unsigned n);
        logic [63:0] r;
        logic        fb;
        int unsigned i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[62:0], fb};
        end
        return r;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // one CSR access, sampled before the commit edge
    task automatic csr_rw(input csr_op_e op, input logic [11:0] idx, input logic [63:0] src,
                          input logic hold, output logic [63:0] old, output logic ill);
        csr_valid = 1'b1;
        csr_op    = op;
        csr_idx   = csr_addr_e'(idx);
        csr_src   = src;
        stall     = hold;
        @(negedge clk);
        old = csr_rdata;
        ill = csr_illegal;
        step();
        csr_valid = 1'b0;
        stall     = 1'b0;
        csr_src   = '0;
    endtask

    task automatic csr_read(input logic [11:0] idx, output logic [63:0] val);
        logic ill;
        csr_rw(CSR_OP_RS, idx, '0, 1'b0, val, ill);
        check_eq($sformatf("csr_illegal on read of 0x%h", idx), ill, 0);
    endtask

    task automatic csr_write(input logic [11:0] idx, input logic [63:0] val);
        logic [63:0] old;
        logic        ill;
        csr_rw(CSR_OP_RW, idx, val, 1'b0, old, ill);
        check_eq($sformatf("csr_illegal on write of 0x%h", idx), ill, 0);
    endtask

    task automatic wb_access(input logic we, input tmr_reg_e adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int unsigned waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        waited   = 0;
        @(negedge clk);
        while (!wb_ack) begin
            waited++;
            if (waited > ACK_LIMIT)
                abort_run("timer bus access got no wb_ack");
            @(negedge clk);
        end
        check_eq("wb_ack latency", waited, 1);
        rdat = wb_dat_r;
        step();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        check_eq("wb_ack after the pulse", wb_ack, 0);  // single pulse
        step();
    endtask

    task automatic wb_write(input tmr_reg_e adr, input logic [31:0] wdat);
        logic [31:0] unused_rd;
        wb_access(1'b1, adr, wdat, unused_rd);
    endtask

    task automatic wb_read(input tmr_reg_e adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic expect_no_redirect(input int unsigned cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_eq("redirect_valid while disabled", redirect_valid, 0);
        end
        step();
    endtask

    task automatic wait_redirect(input int unsigned max_cycles, input logic [63:0] exp_pc);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (!redirect_valid) begin
            n++;
            if (n > max_cycles)
                abort_run("timer interrupt did not redirect in the expected window");
            @(negedge clk);
        end
        check_eq("redirect_pc", redirect_pc, exp_pc);
        step();
    endtask

    task automatic readback_after_reset();
        logic [11:0] zero_idx [0:6] = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                                        CSR_MEPC, CSR_MCAUSE, CSR_MIP};
        logic [63:0] v;
        logic [63:0] w;
        logic [63:0] st_mask;
        int unsigned i;
        csr_read(CSR_MCYCLE, v);
        check_eq("mcycle after reset", v, 0);
        for (i = 0; i < 7; i++) begin
            csr_read(zero_idx[i], v);
            check_eq($sformatf("csr 0x%h after reset", zero_idx[i]), v, 0);
        end
        w = rand_bits(64);
        csr_write(CSR_MSCRATCH, w);
        csr_read(CSR_MSCRATCH, v);
        check_eq("mscratch", v, w);
        scratch_model = w;
        w = rand_bits(64);
        csr_write(CSR_MCAUSE, w);
        csr_read(CSR_MCAUSE, v);
        check_eq("mcause", v, w);
        w = rand_bits(64);
        csr_write(CSR_MTVEC, w);
        csr_read(CSR_MTVEC, v);
        check_eq("mtvec", v, w & ~64'h3);
        w = rand_bits(64);
        csr_write(CSR_MEPC, w);
        csr_read(CSR_MEPC, v);
        check_eq("mepc", v, w & ~64'h3);
        csr_write(CSR_MIE, '1);
        csr_read(CSR_MIE, v);
        check_eq("mie", v, 64'h80);
        csr_write(CSR_MIE, '0);
        // MIE, MPIE, MPP, FS and the derived SD bit
        st_mask = (64'd1 << `CSR_MSTATUS_MIE) | (64'd1 << `CSR_MSTATUS_MPIE)
                | (64'd3 << `CSR_MSTATUS_MPP_LO) | (64'd3 << `CSR_MSTATUS_FS_LO)
                | (64'd1 << 63);
        csr_write(CSR_MSTATUS, '1);
        csr_read(CSR_MSTATUS, v);
        check_eq("mstatus all ones", v, st_mask);
        csr_write(CSR_MSTATUS, '0);
        w = rand_bits(64);
        csr_write(CSR_MCYCLE, w);
        csr_read(CSR_MCYCLE, v);
        check_eq("mcycle after write", v, w);
        repeat (6) step();
        csr_read(CSR_MCYCLE, v);
        check_eq("mcycle 7 cycles later", v, w + 64'd7);
    endtask

    task automatic set_clear_ops();
        logic [63:0] src;
        logic [63:0] old;
        logic        ill;
        repeat (6) begin
            src = rand_bits(64);
            csr_rw(CSR_OP_RS, CSR_MSCRATCH, src, 1'b0, old, ill);
            check_eq("mscratch old on set", old, scratch_model);
            scratch_model = scratch_model | src;
            src = rand_bits(64);
            csr_rw(CSR_OP_RC, CSR_MSCRATCH, src, 1'b0, old, ill);
            check_eq("mscratch old on clear", old, scratch_model);
            scratch_model = scratch_model & ~src;
        end
        csr_rw(CSR_OP_RS, CSR_MSCRATCH, '0, 1'b0, old, ill);
        csr_rw(CSR_OP_RC, CSR_MSCRATCH, '0, 1'b0, old, ill);
        check_eq("mscratch after zero set/clear", old, scratch_model);
        csr_rw(CSR_OP_RW, CSR_MSCRATCH, rand_bits(64), 1'b1, old, ill);
        check_eq("mscratch old under stall", old, scratch_model);
        csr_read(CSR_MSCRATCH, old);
        check_eq("mscratch after stalled write", old, scratch_model);
    endtask

    task automatic illegal_access();
        logic [63:0] old;
        logic        ill;
        csr_rw(CSR_OP_RW, 12'h7C0, rand_bits(64), 1'b0, old, ill);
        check_eq("csr_illegal unknown index", ill, 1);
        check_eq("csr_rdata unknown index", old, 0);
        csr_rw(CSR_OP_RW, CSR_MIP, 64'h80, 1'b0, old, ill);
        check_eq("csr_illegal mip write", ill, 1);
        csr_read(CSR_MIP, old);
        check_eq("mip after illegal write", old, 0);
        csr_read(CSR_MSCRATCH, old);
        check_eq("mscratch after illegal accesses", old, scratch_model);
    endtask

    task automatic ecall_mret_flow(output logic [63:0] tvec);
        logic [63:0] v;
        logic        ill;
        tvec = rand_bits(64) & ~64'h3;
        csr_write(CSR_MTVEC, tvec);
        csr_rw(CSR_OP_RS, CSR_MSTATUS, 64'd1 << `CSR_MSTATUS_MIE, 1'b0, v, ill);
        pc    = rand_bits(64);
        ecall = 1'b1;
        stall = 1'b1;
        @(negedge clk);
        check_eq("redirect_valid ecall under stall", redirect_valid, 0);
        step();
        stall = 1'b0;
        @(negedge clk);
        check_eq("redirect_valid on ecall", redirect_valid, 1);
        check_eq("redirect_pc on ecall", redirect_pc, tvec);
        step();
        ecall = 1'b0;
        csr_read(CSR_MEPC, v);
        check_eq("mepc after ecall", v, pc & ~64'h3);
        csr_read(CSR_MCAUSE, v);
        check_eq("mcause after ecall", v, 64'd11);
        csr_read(CSR_MSTATUS, v);
        check_eq("mstatus.MIE after ecall", v[`CSR_MSTATUS_MIE], 0);
        check_eq("mstatus.MPIE after ecall", v[`CSR_MSTATUS_MPIE], 1);
        check_eq("mstatus.MPP after ecall", v[`CSR_MSTATUS_MPP_LO +: 2], 3);
        mret = 1'b1;
        @(negedge clk);
        check_eq("redirect_valid on mret", redirect_valid, 1);
        check_eq("redirect_pc on mret", redirect_pc, pc & ~64'h3);
        step();
        mret = 1'b0;
        csr_read(CSR_MSTATUS, v);
        check_eq("mstatus.MIE after mret", v[`CSR_MSTATUS_MIE], 1);
        check_eq("mstatus.MPIE after mret", v[`CSR_MSTATUS_MPIE], 1);
        check_eq("mstatus.MPP after mret", v[`CSR_MSTATUS_MPP_LO +: 2], 0);
    endtask

    task automatic bus_protocol();
        logic [31:0] rd;
        logic [31:0] lo;
        logic [31:0] hi;
        wb_read(TMR_MTIMECMP_LO, rd);
        check_eq("mtimecmp lo after reset", rd, 32'hffff_ffff);
        wb_read(TMR_MTIMECMP_HI, rd);
        check_eq("mtimecmp hi after reset", rd, 32'hffff_ffff);
        lo = rand_bits(32);
        hi = rand_bits(32);
        wb_write(TMR_MTIMECMP_LO, lo);
        wb_write(TMR_MTIMECMP_HI, hi);
        wb_read(TMR_MTIMECMP_LO, rd);
        check_eq("mtimecmp lo", rd, lo);
        wb_read(TMR_MTIMECMP_HI, rd);
        check_eq("mtimecmp hi", rd, hi);
    endtask

    task automatic timer_interrupt(input logic [63:0] tvec);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [63:0] target;
        logic [63:0] v;
        logic        ill;
        wb_read(TMR_MTIME_LO, lo);
        wb_read(TMR_MTIME_HI, hi);
        target = {hi, lo} + TMR_MARGIN;
        wb_write(TMR_MTIMECMP_LO, target[31:0]);  // hi half still large here
        wb_write(TMR_MTIMECMP_HI, target[63:32]);
        pc = rand_bits(64);
        csr_rw(CSR_OP_RS, CSR_MSTATUS, 64'd1 << `CSR_MSTATUS_MIE, 1'b0, v, ill);
        retire_valid = 1'b1;
        expect_no_redirect(TMR_MARGIN + 4);  // past the compare point, MTIE still off
        csr_rw(CSR_OP_RW, CSR_MIP, '0, 1'b0, v, ill);
        check_eq("csr_illegal mip write with MTIP set", ill, 1);
        check_eq("csr_rdata mip write with MTIP set", v, 0);
        csr_read(CSR_MIP, v);
        check_eq("mip.MTIP after compare", v, 64'h80);
        csr_rw(CSR_OP_RS, CSR_MIE, 64'h80, 1'b0, v, ill);
        wait_redirect(TMR_MARGIN + 8, tvec);
        retire_valid = 1'b0;
        csr_read(CSR_MCAUSE, v);
        check_eq("mcause after timer trap", v, `CSR_CAUSE_MTI);
        csr_read(CSR_MEPC, v);
        check_eq("mepc after timer trap", v, pc & ~64'h3);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        logic [63:0] tvec;
        clk          = 1'b0;
        wr_mscrstch  = 1'b1;
        csr_valid    = 1'b0;
        csr_op       = CSR_OP_RW;
        csr_idx      = CSR_MSTATUS;
        csr_src      = '0;
        stall        = 1'b0;
        retire_valid = 1'b0;
        pc           = '0;
        ecall        = 1'b0;
        mret         = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = TMR_MTIME_LO;
        wb_dat_w     = '0;
        repeat (5) @(posedge clk);
        #1;
        wr_mscrstch = 1'b0;
        readback_after_reset();
        set_clear_ops();
        illegal_access();
        ecall_mret_flow(tvec);
        bus_protocol();
        timer_interrupt(tvec);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/csr_pkg.sv
hw/tmr_pkg.sv
hw/csr_access.sv
hw/csr_regfile.sv
hw/trap_ctrl.sv
hw/mtimer.sv
hw/mcsr_top.sv
verif/tb_mcsr.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_mcsr
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the simulation output carries the pass line
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
